/* rtl/tmr_consts.svh */
// Sizes of the timer register block
// Register byte offsets and CTRL bit positions

`ifndef TMR_CONSTS_SVH
`define TMR_CONSTS_SVH

// Bus data width and number of register slots
`define TMR_DATA_W      32
`define TMR_NUM_REGS    6

// --------------------------------------------------
// Register offsets
// --------------------------------------------------
`define TMR_ADDR_CTRL   32'h0000_0000
`define TMR_ADDR_LOAD0  32'h0000_0004
`define TMR_ADDR_LOAD1  32'h0000_0008
`define TMR_ADDR_COUNT0 32'h0000_000C
`define TMR_ADDR_COUNT1 32'h0000_0010
`define TMR_ADDR_STATUS 32'h0000_0014

// --------------------------------------------------
// CTRL bits
// --------------------------------------------------
`define TMR_CTRL_EN0    0
`define TMR_CTRL_EN1    1
`define TMR_CTRL_IE0    4
`define TMR_CTRL_IE1    5

`endif

/* rtl/tmr_pkg.sv */
// Shared types of the dual-channel timer
// AXI response codes, register slot names and the counter type

package tmr_pkg;

    // BRESP and RRESP encodings
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // Register slots in address order
    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_LOAD0  = 3'd1,
        REG_LOAD1  = 3'd2,
        REG_COUNT0 = 3'd3,
        REG_COUNT1 = 3'd4,
        REG_STATUS = 3'd5
    } reg_idx_t;

    // Counter value of one timer channel
    typedef logic [31:0] tmr_count_t;

endpackage

/* rtl/axil_reg_slave.sv */
// AXI4-Lite slave holding a flat register array
// Write and read state machines, address decode, byte strobes, responses

`timescale 1ns/1ps
`include "tmr_consts.svh"

module axil_reg_slave
    import tmr_pkg::*;
(
    input  logic                         aclk,
    input  logic                         aresetn,
    // Write address, AxPROT is accepted and ignored
    input  logic [31:0]                  s_axi_awaddr,
    input  logic [2:0]                   s_axi_awprot,
    input  logic                         s_axi_awvalid,
    output logic                         s_axi_awready,
    // Write data
    input  logic [`TMR_DATA_W-1:0]       s_axi_wdata,
    input  logic [`TMR_DATA_W/8-1:0]     s_axi_wstrb,
    input  logic                         s_axi_wvalid,
    output logic                         s_axi_wready,
    // Write response
    output axi_resp_t                    s_axi_bresp,
    output logic                         s_axi_bvalid,
    input  logic                         s_axi_bready,
    // Read address
    input  logic [31:0]                  s_axi_araddr,
    input  logic [2:0]                   s_axi_arprot,
    input  logic                         s_axi_arvalid,
    output logic                         s_axi_arready,
    // Read data
    output logic [`TMR_DATA_W-1:0]       s_axi_rdata,
    output axi_resp_t                    s_axi_rresp,
    output logic                         s_axi_rvalid,
    input  logic                         s_axi_rready,
    // Register array
    output logic [`TMR_DATA_W-1:0]       reg_out      [`TMR_NUM_REGS],
    output logic                         reg_out_strb [`TMR_NUM_REGS],
    input  logic [`TMR_DATA_W-1:0]       reg_in       [`TMR_NUM_REGS]
);

    localparam int NUM_BYTES = `TMR_DATA_W / 8;

    // Slot i answers at ADDR_MAP[i]
    localparam logic [31:0] ADDR_MAP [`TMR_NUM_REGS] = '{
        `TMR_ADDR_CTRL,
        `TMR_ADDR_LOAD0,
        `TMR_ADDR_LOAD1,
        `TMR_ADDR_COUNT0,
        `TMR_ADDR_COUNT1,
        `TMR_ADDR_STATUS
    };

    function automatic logic addr_hit(input logic [31:0] addr);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `TMR_NUM_REGS; i++) begin
            if (addr == ADDR_MAP[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Unmapped addresses read as zero
    function automatic logic [`TMR_DATA_W-1:0] read_mux(input logic [31:0] addr);
        logic [`TMR_DATA_W-1:0] data;
        data = '0;
        for (int i = 0; i < `TMR_NUM_REGS; i++) begin
            if (addr == ADDR_MAP[i]) begin
                data = reg_in[i];
            end
        end
        return data;
    endfunction

    // --------------------------------------------------
    // Write state machine
    // --------------------------------------------------
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,    // address held, waiting for data
        WR_DATA,    // data held, waiting for address
        WR_RESP
    } wr_state_t;

    wr_state_t                  wr_state;
    wr_state_t                  wr_state_next;
    logic                       aw_hs;
    logic                       w_hs;
    logic                       wr_fire;
    logic [31:0]                awaddr_q;
    logic [`TMR_DATA_W-1:0]     wdata_q;
    logic [NUM_BYTES-1:0]       wstrb_q;
    logic [31:0]                wr_addr;
    logic [`TMR_DATA_W-1:0]     wr_data;
    logic [NUM_BYTES-1:0]       wr_strb;

    assign aw_hs = s_axi_awvalid && s_axi_awready;
    assign w_hs  = s_axi_wvalid && s_axi_wready;

    always_comb begin
        wr_state_next = wr_state;
        case (wr_state)
            WR_IDLE: begin
                if (aw_hs && w_hs) begin
                    wr_state_next = WR_RESP;
                end else if (aw_hs) begin
                    wr_state_next = WR_ADDR;
                end else if (w_hs) begin
                    wr_state_next = WR_DATA;
                end
            end
            WR_ADDR: if (w_hs) wr_state_next = WR_RESP;
            WR_DATA: if (aw_hs) wr_state_next = WR_RESP;
            WR_RESP: if (s_axi_bready) wr_state_next = WR_IDLE;
            default: wr_state_next = WR_IDLE;
        endcase
    end

    // Ready only on the channel still missing, never while B is pending
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_state      <= WR_IDLE;
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
        end else begin
            wr_state      <= wr_state_next;
            s_axi_awready <= (wr_state_next == WR_IDLE) || (wr_state_next == WR_DATA);
            s_axi_wready  <= (wr_state_next == WR_IDLE) || (wr_state_next == WR_ADDR);
            s_axi_bvalid  <= (wr_state_next == WR_RESP);
        end
    end

    // Hold whichever half arrived first
    always_ff @(posedge aclk) begin
        if (wr_state == WR_IDLE && aw_hs && !w_hs) begin
            awaddr_q <= s_axi_awaddr;
        end
        if (wr_state == WR_IDLE && w_hs && !aw_hs) begin
            wdata_q <= s_axi_wdata;
            wstrb_q <= s_axi_wstrb;
        end
    end

    assign wr_fire = (wr_state == WR_IDLE && aw_hs && w_hs) ||
                     (wr_state == WR_ADDR && w_hs) ||
                     (wr_state == WR_DATA && aw_hs);

    assign wr_addr = (wr_state == WR_ADDR) ? awaddr_q : s_axi_awaddr;
    assign wr_data = (wr_state == WR_DATA) ? wdata_q : s_axi_wdata;
    assign wr_strb = (wr_state == WR_DATA) ? wstrb_q : s_axi_wstrb;

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            s_axi_bresp <= addr_hit(wr_addr) ? OKAY : DECERR;
        end
    end

    // Byte-wise register update and one-cycle write pulse
    for (genvar i = 0; i < `TMR_NUM_REGS; i++) begin : g_reg
        always_ff @(posedge aclk) begin
            if (!aresetn) begin
                reg_out[i]      <= '0;
                reg_out_strb[i] <= 1'b0;
            end else begin
                reg_out_strb[i] <= wr_fire && (wr_addr == ADDR_MAP[i]);
                for (int j = 0; j < NUM_BYTES; j++) begin
                    if (wr_fire && wr_addr == ADDR_MAP[i] && wr_strb[j]) begin
                        reg_out[i][j*8 +: 8] <= wr_data[j*8 +: 8];
                    end
                end
            end
        end
    end

    // --------------------------------------------------
    // Read state machine
    // --------------------------------------------------
    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_t;

    rd_state_t rd_state;
    rd_state_t rd_state_next;
    logic      ar_hs;

    assign ar_hs = s_axi_arvalid && s_axi_arready;

    always_comb begin
        rd_state_next = rd_state;
        case (rd_state)
            RD_IDLE: if (ar_hs) rd_state_next = RD_DATA;
            RD_DATA: if (s_axi_rready) rd_state_next = RD_IDLE;
            default: rd_state_next = RD_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_state      <= RD_IDLE;
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            rd_state      <= rd_state_next;
            s_axi_arready <= (rd_state_next == RD_IDLE);
            s_axi_rvalid  <= (rd_state_next == RD_DATA);
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            s_axi_rdata <= read_mux(s_axi_araddr);
            s_axi_rresp <= addr_hit(s_axi_araddr) ? OKAY : DECERR;
        end
    end

    // Responses stay put under back-pressure
    a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp));

    a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axi_rvalid && !s_axi_rready |=>
            s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp));

endmodule

/* rtl/tmr_channel.sv */
// One timer channel
// Reloading down counter with a one-cycle expiry pulse

`timescale 1ns/1ps

module tmr_channel
    import tmr_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       enable,
    input  tmr_count_t load,
    output tmr_count_t count,
    output logic       expire
);

    // --------------------------------------------------
    // Counter
    // --------------------------------------------------
    // Period is load+1 cycles while enabled
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            count  <= '0;
            expire <= 1'b0;
        end else if (!enable) begin
            // Idle channel tracks the programmed load value
            count  <= load;
            expire <= 1'b0;
        end else if (count == '0) begin
            count  <= load;
            expire <= 1'b1;
        end else if (count > load) begin
            // A smaller load restarts the period
            count  <= load;
            expire <= 1'b0;
        end else begin
            count  <= count - 1;
            expire <= 1'b0;
        end
    end

    // Once load has settled the counter stays inside its range
    a_count_range: assert property (@(posedge aclk) disable iff (!aresetn)
        $stable(load) |-> count <= load);

endmodule

/* rtl/tmr_irq_status.sv */
// Sticky expiry status with write-one-to-clear
// Masked OR of the status bits drives the interrupt line

`timescale 1ns/1ps

module tmr_irq_status (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       expire0,
    input  logic       expire1,
    input  logic [1:0] irq_en,
    input  logic       clr_wr,
    input  logic [1:0] clr_data,
    output logic [1:0] status,
    output logic       irq
);

    logic [1:0] set_bits;
    logic [1:0] clr_bits;

    // Bit 0 belongs to channel 0 and bit 1 to channel 1
    assign set_bits = {expire1, expire0};
    assign clr_bits = clr_wr ? clr_data : 2'b00;

    // --------------------------------------------------
    // Status register
    // --------------------------------------------------
    // A new event beats a clear in the same cycle
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            status <= 2'b00;
        end else begin
            status <= (status & ~clr_bits) | set_bits;
        end
    end

    // Level interrupt from registered status only
    assign irq = |(status & irq_en);

endmodule

/* rtl/dual_timer_top.sv */
// Dual-channel timer with an AXI4-Lite register block
// Register slave, two timer channels and the interrupt status block

`timescale 1ns/1ps
`include "tmr_consts.svh"

module dual_timer_top
    import tmr_pkg::*;
(
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic [31:0]                  s_axi_awaddr,
    input  logic [2:0]                   s_axi_awprot,
    input  logic                         s_axi_awvalid,
    output logic                         s_axi_awready,
    input  logic [`TMR_DATA_W-1:0]       s_axi_wdata,
    input  logic [`TMR_DATA_W/8-1:0]     s_axi_wstrb,
    input  logic                         s_axi_wvalid,
    output logic                         s_axi_wready,
    output axi_resp_t                    s_axi_bresp,
    output logic                         s_axi_bvalid,
    input  logic                         s_axi_bready,
    input  logic [31:0]                  s_axi_araddr,
    input  logic [2:0]                   s_axi_arprot,
    input  logic                         s_axi_arvalid,
    output logic                         s_axi_arready,
    output logic [`TMR_DATA_W-1:0]       s_axi_rdata,
    output axi_resp_t                    s_axi_rresp,
    output logic                         s_axi_rvalid,
    input  logic                         s_axi_rready,
    output logic                         irq
);

    logic [`TMR_DATA_W-1:0] reg_out      [`TMR_NUM_REGS];
    logic                   reg_out_strb [`TMR_NUM_REGS];
    logic [`TMR_DATA_W-1:0] reg_in       [`TMR_NUM_REGS];
    tmr_count_t             count0;
    tmr_count_t             count1;
    logic                   expire0;
    logic                   expire1;
    logic [1:0]             status;

    // --------------------------------------------------
    // Read-back routing
    // --------------------------------------------------
    assign reg_in[REG_CTRL]   = reg_out[REG_CTRL];
    assign reg_in[REG_LOAD0]  = reg_out[REG_LOAD0];
    assign reg_in[REG_LOAD1]  = reg_out[REG_LOAD1];
    // COUNT writes land in reg_out but read back the live counters
    assign reg_in[REG_COUNT0] = count0;
    assign reg_in[REG_COUNT1] = count1;
    assign reg_in[REG_STATUS] = {{(`TMR_DATA_W-2){1'b0}}, status};

    axil_reg_slave u_regs (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awprot  (s_axi_awprot),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arprot  (s_axi_arprot),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .reg_out       (reg_out),
        .reg_out_strb  (reg_out_strb),
        .reg_in        (reg_in)
    );

    // --------------------------------------------------
    // Timer channels
    // --------------------------------------------------
    tmr_channel u_ch0 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .enable  (reg_out[REG_CTRL][`TMR_CTRL_EN0]),
        .load    (reg_out[REG_LOAD0]),
        .count   (count0),
        .expire  (expire0)
    );

    tmr_channel u_ch1 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .enable  (reg_out[REG_CTRL][`TMR_CTRL_EN1]),
        .load    (reg_out[REG_LOAD1]),
        .count   (count1),
        .expire  (expire1)
    );

    // Clear data is the freshly written STATUS word
    tmr_irq_status u_status (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .expire0  (expire0),
        .expire1  (expire1),
        .irq_en   ({reg_out[REG_CTRL][`TMR_CTRL_IE1], reg_out[REG_CTRL][`TMR_CTRL_IE0]}),
        .clr_wr   (reg_out_strb[REG_STATUS]),
        .clr_data (reg_out[REG_STATUS][1:0]),
        .status   (status),
        .irq      (irq)
    );

endmodule

/* tb/tb_checker.sv */
// Response checker for the dual-channel timer testbench
// Compares B, R and irq with queued expected values, watches handshakes

`timescale 1ns/1ps
`include "tmr_consts.svh"

module tb_checker
    import tmr_pkg::*;
(
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   s_axi_awready,
    input  logic                   s_axi_wready,
    input  axi_resp_t              s_axi_bresp,
    input  logic                   s_axi_bvalid,
    input  logic                   s_axi_bready,
    input  logic                   s_axi_arready,
    input  logic [`TMR_DATA_W-1:0] s_axi_rdata,
    input  axi_resp_t              s_axi_rresp,
    input  logic                   s_axi_rvalid,
    input  logic                   s_axi_rready,
    input  logic                   irq,
    input  logic                   exp_push,
    input  logic [1:0]             exp_kind,
    input  logic [`TMR_DATA_W-1:0] exp_data,
    input  axi_resp_t              exp_resp,
    output int                     check_count,
    output int                     mismatch_count,
    output int                     protocol_count,
    output int                     pending
);

    localparam logic [1:0] EXP_B     = 2'd0;
    localparam logic [1:0] EXP_R     = 2'd1;
    localparam logic [1:0] EXP_RANGE = 2'd2;
    localparam logic [1:0] EXP_IRQ   = 2'd3;

    logic [1:0]             kind_q [$];
    logic [`TMR_DATA_W-1:0] data_q [$];
    axi_resp_t              resp_q [$];

    // Response seen stalled at the previous edge
    logic                   b_stall;
    axi_resp_t              bresp_held;
    logic                   r_stall;
    logic [`TMR_DATA_W-1:0] rdata_held;
    axi_resp_t              rresp_held;

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic report_protocol(input string msg);
        protocol_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    always @(posedge aclk) begin : check_edge
        logic [1:0]             kind;
        logic [`TMR_DATA_W-1:0] data;
        axi_resp_t              resp;
        if (!aresetn) begin
            b_stall = 1'b0;
            r_stall = 1'b0;
        end else begin
            // --------------------------------------------------
            // Stability under back-pressure
            // --------------------------------------------------
            if (b_stall && !(s_axi_bvalid && s_axi_bresp == bresp_held)) begin
                report_protocol("write response changed or dropped before bready");
            end
            if (r_stall && !(s_axi_rvalid && s_axi_rdata == rdata_held &&
                             s_axi_rresp == rresp_held)) begin
                report_protocol("read response changed or dropped before rready");
            end
            b_stall    = s_axi_bvalid && !s_axi_bready;
            bresp_held = s_axi_bresp;
            r_stall    = s_axi_rvalid && !s_axi_rready;
            rdata_held = s_axi_rdata;
            rresp_held = s_axi_rresp;

            // Nothing new is accepted while a response is pending
            if (s_axi_bvalid && (s_axi_awready || s_axi_wready)) begin
                report_protocol("write address or data ready while a write response is pending");
            end
            if (s_axi_rvalid && s_axi_arready) begin
                report_protocol("read address ready while a read response is pending");
            end

            // irq checks are immediate while the rest wait for their response
            if (exp_push && exp_kind == EXP_IRQ) begin
                check_count++;
                if (irq !== exp_data[0]) begin
                    report_mismatch($sformatf("irq %b, expected %b", irq, exp_data[0]));
                end
            end else if (exp_push) begin
                kind_q.push_back(exp_kind);
                data_q.push_back(exp_data);
                resp_q.push_back(exp_resp);
            end

            if ((s_axi_bvalid && s_axi_bready) || (s_axi_rvalid && s_axi_rready)) begin
                if (kind_q.size() == 0) begin
                    report_protocol("response arrived with nothing expected");
                end else begin
                    kind = kind_q.pop_front();
                    data = data_q.pop_front();
                    resp = resp_q.pop_front();
                    check_count++;
                    if (s_axi_bvalid && s_axi_bready) begin
                        if (kind != EXP_B) begin
                            report_protocol("write response arrived where a read was expected");
                        end else if (s_axi_bresp !== resp) begin
                            report_mismatch($sformatf("BRESP %0d, expected %0d",
                                                      s_axi_bresp, resp));
                        end
                    end else if (kind == EXP_B) begin
                        report_protocol("read response arrived where a write was expected");
                    end else begin
                        if (s_axi_rresp !== resp) begin
                            report_mismatch($sformatf("RRESP %0d, expected %0d",
                                                      s_axi_rresp, resp));
                        end
                        if (kind == EXP_R && s_axi_rdata !== data) begin
                            report_mismatch($sformatf("RDATA %h, expected %h",
                                                      s_axi_rdata, data));
                        end
                        if (kind == EXP_RANGE && s_axi_rdata > data) begin
                            report_mismatch($sformatf("RDATA %0d outside 0 to %0d",
                                                      s_axi_rdata, data));
                        end
                    end
                end
            end
        end
        pending = kind_q.size();
    end

endmodule

/* tb/tb_dual_timer.sv */
// Testbench top for the dual-channel timer
// Clock, reset, pattern reader, AXI4-Lite master driver, watchdog and summary

`timescale 1ns/1ps
`include "tmr_consts.svh"

module tb_dual_timer
    import tmr_pkg::*;
();

    localparam logic [1:0] EXP_B     = 2'd0;
    localparam logic [1:0] EXP_R     = 2'd1;
    localparam logic [1:0] EXP_RANGE = 2'd2;
    localparam logic [1:0] EXP_IRQ   = 2'd3;

    logic                       aclk;
    logic                       aresetn;
    logic [31:0]                s_axi_awaddr;
    logic [2:0]                 s_axi_awprot;
    logic                       s_axi_awvalid;
    logic                       s_axi_awready;
    logic [`TMR_DATA_W-1:0]     s_axi_wdata;
    logic [`TMR_DATA_W/8-1:0]   s_axi_wstrb;
    logic                       s_axi_wvalid;
    logic                       s_axi_wready;
    axi_resp_t                  s_axi_bresp;
    logic                       s_axi_bvalid;
    logic                       s_axi_bready;
    logic [31:0]                s_axi_araddr;
    logic [2:0]                 s_axi_arprot;
    logic                       s_axi_arvalid;
    logic                       s_axi_arready;
    logic [`TMR_DATA_W-1:0]     s_axi_rdata;
    axi_resp_t                  s_axi_rresp;
    logic                       s_axi_rvalid;
    logic                       s_axi_rready;
    logic                       irq;

    // Expected values handed to the checker
    logic                       exp_push;
    logic [1:0]                 exp_kind;
    logic [`TMR_DATA_W-1:0]     exp_data;
    axi_resp_t                  exp_resp;
    int                         check_count;
    int                         mismatch_count;
    int                         protocol_count;
    int                         pending;

    // One op letter and up to four hex fields per pattern line
    byte                        op_q  [$];
    logic [3:0][31:0]           arg_q [$];
    int                         limit_cycles;
    logic                       patterns_loaded;
    int                         other_errors;
    logic [31:0]                lfsr_state;

    dual_timer_top DUT (.*);

    tb_checker u_checker (.*);

    always #5 aclk = ~aclk;

    // --------------------------------------------------
    // Random choices
    // --------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [1:0] bits);
        bits = 2'b00;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[0], lfsr_state[0]};
        end
    endtask

    // --------------------------------------------------
    // Pattern file
    // --------------------------------------------------
    task automatic load_patterns();
        int          fd;
        int          code;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        fd = $fopen("tb/dual_timer_patterns.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Cannot open the pattern file tb/dual_timer_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 1 && line.getc(0) != "#") begin
                    a = '0;
                    b = '0;
                    c = '0;
                    d = '0;
                    code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
                    op_q.push_back(line.getc(0));
                    arg_q.push_back({d, c, b, a});
                    // Budget per operation plus the waits themselves
                    limit_cycles += 200;
                    if (line.getc(0) == "T") begin
                        limit_cycles += a;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------------------------------------
    // AXI4-Lite master
    // --------------------------------------------------
    task automatic push_expect(input logic [1:0] kind, input logic [31:0] data,
                               input logic [1:0] resp);
        exp_kind = kind;
        exp_data = data;
        exp_resp = axi_resp_t'(resp);
        exp_push = 1'b1;
        @(posedge aclk);
        #1;
        exp_push = 1'b0;
    endtask

    // Ready is registered so its value 1 ns after an edge holds at the next edge
    task automatic send_aw(input logic [31:0] addr);
        logic ready;
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        do begin
            ready = s_axi_awready;
            @(posedge aclk);
            #1;
        end while (!ready);
        s_axi_awvalid = 1'b0;
    endtask

    task automatic send_w(input logic [31:0] data, input logic [`TMR_DATA_W/8-1:0] strb);
        logic ready;
        s_axi_wdata  = data;
        s_axi_wstrb  = strb;
        s_axi_wvalid = 1'b1;
        do begin
            ready = s_axi_wready;
            @(posedge aclk);
            #1;
        end while (!ready);
        s_axi_wvalid = 1'b0;
    endtask

    task automatic send_ar(input logic [31:0] addr);
        logic ready;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        do begin
            ready = s_axi_arready;
            @(posedge aclk);
            #1;
        end while (!ready);
        s_axi_arvalid = 1'b0;
    endtask

    // Accept B or R after 0 to 3 cycles of back-pressure
    task automatic wait_response(input logic is_read);
        logic [1:0] delay;
        take_bits(2, delay);
        while (!(is_read ? s_axi_rvalid : s_axi_bvalid)) begin
            @(posedge aclk);
            #1;
        end
        repeat (delay) begin
            @(posedge aclk);
            #1;
        end
        s_axi_rready = is_read;
        s_axi_bready = !is_read;
        @(posedge aclk);
        #1;
        s_axi_rready = 1'b0;
        s_axi_bready = 1'b0;
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [`TMR_DATA_W/8-1:0] strb, input logic [1:0] resp);
        logic [1:0] order;
        push_expect(EXP_B, '0, resp);
        take_bits(2, order);
        case (order)
            2'd1: begin
                send_aw(addr);
                send_w(data, strb);
            end
            2'd2: begin
                send_w(data, strb);
                send_aw(addr);
            end
            default: begin
                fork
                    send_aw(addr);
                    send_w(data, strb);
                join
            end
        endcase
        wait_response(1'b0);
    endtask

    task automatic do_read(input logic [1:0] kind, input logic [31:0] addr,
                           input logic [31:0] data, input logic [1:0] resp);
        push_expect(kind, data, resp);
        send_ar(addr);
        wait_response(1'b1);
    endtask

    task automatic do_wait(input logic [31:0] cycles, input logic level);
        repeat (cycles) begin
            @(posedge aclk);
            #1;
        end
        push_expect(EXP_IRQ, {31'b0, level}, 2'b00);
    endtask

    task automatic run_op(input byte op, input logic [3:0][31:0] arg);
        case (op)
            "W": do_write(arg[0], arg[1], arg[2][`TMR_DATA_W/8-1:0], arg[3][1:0]);
            "R": do_read(EXP_R, arg[0], arg[1], arg[2][1:0]);
            "C": do_read(EXP_RANGE, arg[0], arg[1], arg[2][1:0]);
            "T": do_wait(arg[0], arg[1][0]);
            default: begin
                other_errors++;
                $display("Unknown operation '%c' in the pattern file", op);
            end
        endcase
    endtask

    task automatic print_summary();
        $display("Summary: %0d checks, %0d mismatches, %0d protocol errors, %0d other errors",
                 check_count, mismatch_count, protocol_count, other_errors);
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        aclk            = 1'b0;
        aresetn         = 1'b0;
        s_axi_awaddr    = '0;
        s_axi_awprot    = '0;
        s_axi_awvalid   = 1'b0;
        s_axi_wdata     = '0;
        s_axi_wstrb     = '0;
        s_axi_wvalid    = 1'b0;
        s_axi_bready    = 1'b0;
        s_axi_araddr    = '0;
        s_axi_arprot    = '0;
        s_axi_arvalid   = 1'b0;
        s_axi_rready    = 1'b0;
        exp_push        = 1'b0;
        exp_kind        = EXP_B;
        exp_data        = '0;
        exp_resp        = OKAY;
        limit_cycles    = 0;
        other_errors    = 0;
        patterns_loaded = 1'b0;
        lfsr_state      = 32'hc3c7_f90c;
        load_patterns();
        patterns_loaded = 1'b1;
        repeat (5) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(posedge aclk);
        #1;
        foreach (op_q[i]) begin
            run_op(op_q[i], arg_q[i]);
        end
        repeat (4) @(posedge aclk);
        if (pending != 0) begin
            other_errors++;
            $display("%0d expected responses never arrived", pending);
        end
        print_summary();
        if (mismatch_count + protocol_count + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Reset and closing cycles on top of the pattern budget
    initial begin
        wait (patterns_loaded);
        repeat (limit_cycles + 20) @(posedge aclk);
        other_errors++;
        $display("Timeout, the pattern run did not finish within %0d cycles", limit_cycles);
        print_summary();
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tb/dual_timer_patterns.txt */
# Columns, all fields hex, resp 0 is OKAY and 3 is DECERR
#   W addr data strb resp | R addr data resp | C addr max resp | T cycles irq
W 00 ffffff00 e 0
R 00 ffffff00 0
W 04 12345678 f 0
R 04 12345678 0
W 04 aabbccdd 5 0
R 04 12bb56dd 0
W 08 cafef00d f 0
W 08 00001100 2 0
R 08 cafe110d 0
W 1c 11111111 f 3
W 40 22222222 f 3
R 1c 00000000 3
R 40 00000000 3
R 04 12bb56dd 0
R 08 cafe110d 0
W 10 deadbeef f 0
R 10 cafe110d 0
W 04 00000014 f 0
W 00 00000001 f 0
T 64 0
R 14 00000001 0
C 0c 00000014 0
R 10 cafe110d 0
W 14 00000002 1 0
R 14 00000001 0
W 00 00000000 f 0
W 14 00000001 1 0
R 14 00000000 0
T 5 0
W 00 00000011 f 0
T 64 1
R 14 00000001 0
W 00 00000010 f 0
T 2 1

/* tb.f */
+incdir+rtl
rtl/tmr_pkg.sv
rtl/axil_reg_slave.sv
rtl/tmr_channel.sv
rtl/tmr_irq_status.sv
rtl/dual_timer_top.sv
tb/tb_checker.sv
tb/tb_dual_timer.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_dual_timer
FILELIST  := tb.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
